/* common/rv_pkg.sv */
package rv_pkg;

   typedef logic [31:0] word_t;
   typedef logic [4:0]  reg_idx_t;
   typedef logic [31:0] instr_t;

   // major opcode field in instr[6:0]
   localparam logic [6:0] OPC_OP     = 7'b0110011;
   localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
   localparam logic [6:0] OPC_LUI    = 7'b0110111;
   localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
   localparam logic [6:0] OPC_JAL    = 7'b1101111;
   localparam logic [6:0] OPC_JALR   = 7'b1100111;
   localparam logic [6:0] OPC_BRANCH = 7'b1100011;

   localparam logic [6:0] F7_BASE = 7'b0000000;
   localparam logic [6:0] F7_ALT  = 7'b0100000;

   typedef enum logic [1:0] {
      S_IDLE,
      S_DECODE,
      S_EXECUTE,
      S_WRITEBACK
   } ctrl_state_e;

   typedef enum logic [4:0] {
      ADD,
      SUB,
      SLL,
      SLT,
      SLTU,
      XOR,
      SRL,
      SRA,
      OR,
      AND,
      LUI,
      AUIPC,
      JAL,
      JALR,
      BEQ,
      BNE,
      BLT,
      BGE,
      BLTU,
      BGEU,
      ILLEGAL
   } alu_op_e;

endpackage

/* common/decoded_if.sv */
`timescale 1ns/10ps

interface decoded_if;
   import rv_pkg::*;

   alu_op_e  op;
   // second operand is imm instead of rs2
   logic     use_imm;
   reg_idx_t rd;
   reg_idx_t rs1;
   reg_idx_t rs2;
   word_t    imm;
   word_t    pc;

   modport producer (
      output op,
      output use_imm,
      output rd,
      output rs1,
      output rs2,
      output imm,
      output pc
   );

   modport consumer (
      input op,
      input use_imm,
      input rd,
      input rs1,
      input rs2,
      input imm,
      input pc
   );

endinterface

/* hw/exec_ctrl.sv */
`timescale 1ns/10ps

module exec_ctrl (
   input  logic                clk,
   input  logic                rst_n,
   input  logic                in_valid,
   input  rv_pkg::instr_t      in_instr,
   input  rv_pkg::word_t       in_pc,
   output rv_pkg::instr_t      instr_raw,
   output rv_pkg::word_t       pc,
   output rv_pkg::ctrl_state_e state,
   output logic                busy
);
   import rv_pkg::*;

   ctrl_state_e state_nxt;
   logic        accept;

   // strobes outside idle are dropped
   assign accept = in_valid && (state == S_IDLE);
   assign busy   = (state != S_IDLE);

   always_comb begin
      state_nxt = state;
      case (state)
         S_IDLE:      if (accept) state_nxt = S_DECODE;
         S_DECODE:    state_nxt = S_EXECUTE;
         S_EXECUTE:   state_nxt = S_WRITEBACK;
         S_WRITEBACK: state_nxt = S_IDLE;
         default:     state_nxt = S_IDLE;
      endcase
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state <= S_IDLE;
      end else begin
         state <= state_nxt;
      end
   end

   // instruction word held for the decode cycle
   always_ff @(posedge clk) begin
      if (accept) begin
         instr_raw <= in_instr;
         pc        <= in_pc;
      end
   end

endmodule

/* decode/instr_decoder.sv */
`timescale 1ns/10ps

module instr_decoder #(
   parameter int REG_COUNT = 32
) (
   input  logic                clk,
   input  logic                rst_n,
   input  rv_pkg::ctrl_state_e state,
   input  rv_pkg::instr_t      instr_raw,
   input  rv_pkg::word_t       pc,
   decoded_if.producer         dec
);
   import rv_pkg::*;

   logic [6:0] opcode;
   logic [2:0] funct3;
   logic [6:0] funct7;
   reg_idx_t   rd_f;
   reg_idx_t   rs1_f;
   reg_idx_t   rs2_f;
   logic       r_fmt;
   logic       i_fmt;
   logic       b_fmt;
   logic       u_fmt;
   logic       j_fmt;
   logic       rd_used;
   logic       rs1_used;
   logic       rs2_used;
   logic       idx_ok;
   logic       legal;
   alu_op_e    op_nxt;
   word_t      imm_nxt;

   assign opcode = instr_raw[6:0];
   assign rd_f   = instr_raw[11:7];
   assign funct3 = instr_raw[14:12];
   assign rs1_f  = instr_raw[19:15];
   assign rs2_f  = instr_raw[24:20];
   assign funct7 = instr_raw[31:25];

   assign r_fmt = (opcode == OPC_OP);
   assign i_fmt = (opcode == OPC_OP_IMM) || (opcode == OPC_JALR);
   assign b_fmt = (opcode == OPC_BRANCH);
   assign u_fmt = (opcode == OPC_LUI) || (opcode == OPC_AUIPC);
   assign j_fmt = (opcode == OPC_JAL);

   assign rd_used  = r_fmt || i_fmt || u_fmt || j_fmt;
   assign rs1_used = r_fmt || i_fmt || b_fmt;
   assign rs2_used = r_fmt || b_fmt;

   // rv32e has only x0..x15
   assign idx_ok = (!rd_used  || (32'(rd_f)  < REG_COUNT)) &&
                   (!rs1_used || (32'(rs1_f) < REG_COUNT)) &&
                   (!rs2_used || (32'(rs2_f) < REG_COUNT));

   assign legal = (op_nxt != ILLEGAL) && idx_ok;

   always_comb begin
      op_nxt = ILLEGAL;
      case (opcode)
         OPC_OP: begin
            if (funct7 == F7_BASE) begin
               case (funct3)
                  3'b000:  op_nxt = ADD;
                  3'b001:  op_nxt = SLL;
                  3'b010:  op_nxt = SLT;
                  3'b011:  op_nxt = SLTU;
                  3'b100:  op_nxt = XOR;
                  3'b101:  op_nxt = SRL;
                  3'b110:  op_nxt = OR;
                  default: op_nxt = AND;
               endcase
            end else if (funct7 == F7_ALT) begin
               if (funct3 == 3'b000) begin
                  op_nxt = SUB;
               end else if (funct3 == 3'b101) begin
                  op_nxt = SRA;
               end
            end
         end
         OPC_OP_IMM: begin
            case (funct3)
               3'b000: op_nxt = ADD;
               3'b010: op_nxt = SLT;
               3'b011: op_nxt = SLTU;
               3'b100: op_nxt = XOR;
               3'b110: op_nxt = OR;
               3'b111: op_nxt = AND;
               // shamt sits in imm[4:0] and funct7 picks the shift kind
               3'b001: if (funct7 == F7_BASE) op_nxt = SLL;
               default: begin
                  if (funct7 == F7_BASE) begin
                     op_nxt = SRL;
                  end else if (funct7 == F7_ALT) begin
                     op_nxt = SRA;
                  end
               end
            endcase
         end
         OPC_LUI:   op_nxt = LUI;
         OPC_AUIPC: op_nxt = AUIPC;
         OPC_JAL:   op_nxt = JAL;
         OPC_JALR:  if (funct3 == 3'b000) op_nxt = JALR;
         OPC_BRANCH: begin
            case (funct3)
               3'b000:  op_nxt = BEQ;
               3'b001:  op_nxt = BNE;
               3'b100:  op_nxt = BLT;
               3'b101:  op_nxt = BGE;
               3'b110:  op_nxt = BLTU;
               3'b111:  op_nxt = BGEU;
               default: op_nxt = ILLEGAL;
            endcase
         end
         default: op_nxt = ILLEGAL;
      endcase
   end

   always_comb begin
      imm_nxt = '0;
      if (i_fmt) begin
         imm_nxt = {{20{instr_raw[31]}}, instr_raw[31:20]};
      end else if (b_fmt) begin
         imm_nxt = {{19{instr_raw[31]}}, instr_raw[31], instr_raw[7],
                    instr_raw[30:25], instr_raw[11:8], 1'b0};
      end else if (u_fmt) begin
         imm_nxt = {instr_raw[31:12], 12'b0};
      end else if (j_fmt) begin
         imm_nxt = {{11{instr_raw[31]}}, instr_raw[31], instr_raw[19:12],
                    instr_raw[20], instr_raw[30:21], 1'b0};
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         dec.op      <= ILLEGAL;
         dec.use_imm <= 1'b0;
         dec.rd      <= '0;
         dec.rs1     <= '0;
         dec.rs2     <= '0;
         dec.imm     <= '0;
         dec.pc      <= '0;
      end else if (state == S_DECODE) begin
         dec.op      <= legal ? op_nxt : ILLEGAL;
         dec.use_imm <= i_fmt;
         // illegal words get rd = x0
         dec.rd      <= (legal && rd_used) ? rd_f : '0;
         dec.rs1     <= rs1_used ? rs1_f : '0;
         dec.rs2     <= rs2_used ? rs2_f : '0;
         dec.imm     <= imm_nxt;
         dec.pc      <= pc;
      end
   end

endmodule

/* hw/reg_file.sv */
`timescale 1ns/10ps

module reg_file #(
   parameter int REG_COUNT = 32
) (
   input  logic             clk,
   input  logic             rst_n,
   input  rv_pkg::reg_idx_t rs1_addr,
   input  rv_pkg::reg_idx_t rs2_addr,
   output rv_pkg::word_t    rs1_data,
   output rv_pkg::word_t    rs2_data,
   input  logic             we,
   input  rv_pkg::reg_idx_t wr_addr,
   input  rv_pkg::word_t    wr_data
);
   import rv_pkg::*;

   word_t regs [REG_COUNT];
   logic  wr_ok;

   // x0 and out-of-range indices are never written
   assign wr_ok = we && (wr_addr != '0) && (32'(wr_addr) < REG_COUNT);

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         for (int i = 0; i < REG_COUNT; i++) begin
            regs[i] <= '0;
         end
      end else if (wr_ok) begin
         regs[wr_addr] <= wr_data;
      end
   end

   always_comb begin
      rs1_data = '0;
      if ((rs1_addr != '0) && (32'(rs1_addr) < REG_COUNT)) begin
         rs1_data = regs[rs1_addr];
      end
   end

   always_comb begin
      rs2_data = '0;
      if ((rs2_addr != '0) && (32'(rs2_addr) < REG_COUNT)) begin
         rs2_data = regs[rs2_addr];
      end
   end

endmodule

/* exec/int_alu.sv */
`timescale 1ns/10ps

module int_alu (
   input  logic                clk,
   input  logic                rst_n,
   input  rv_pkg::ctrl_state_e state,
   decoded_if.consumer         dec,
   input  rv_pkg::word_t       rs1_data,
   input  rv_pkg::word_t       rs2_data,
   output rv_pkg::word_t       result,
   output rv_pkg::word_t       target,
   output logic                taken,
   output logic                wr_en,
   output logic                illegal
);
   import rv_pkg::*;

   word_t op_a;
   word_t op_b;
   word_t res_nxt;
   word_t tgt_nxt;
   logic  taken_nxt;
   logic  is_branch;

   assign op_a = rs1_data;
   assign op_b = dec.use_imm ? dec.imm : rs2_data;

   assign is_branch = (dec.op == BEQ) || (dec.op == BNE) || (dec.op == BLT) ||
                      (dec.op == BGE) || (dec.op == BLTU) || (dec.op == BGEU);

   always_comb begin
      res_nxt   = '0;
      taken_nxt = 1'b0;
      case (dec.op)
         ADD:   res_nxt = op_a + op_b;
         SUB:   res_nxt = op_a - op_b;
         SLL:   res_nxt = op_a << op_b[4:0];
         SLT:   res_nxt = ($signed(op_a) < $signed(op_b)) ? 32'd1 : 32'd0;
         SLTU:  res_nxt = (op_a < op_b) ? 32'd1 : 32'd0;
         XOR:   res_nxt = op_a ^ op_b;
         SRL:   res_nxt = op_a >> op_b[4:0];
         SRA:   res_nxt = $signed(op_a) >>> op_b[4:0];
         OR:    res_nxt = op_a | op_b;
         AND:   res_nxt = op_a & op_b;
         LUI:   res_nxt = dec.imm;
         AUIPC: res_nxt = dec.pc + dec.imm;
         // link address
         JAL, JALR: begin
            res_nxt   = dec.pc + 32'd4;
            taken_nxt = 1'b1;
         end
         BEQ:   taken_nxt = (op_a == op_b);
         BNE:   taken_nxt = (op_a != op_b);
         BLT:   taken_nxt = ($signed(op_a) < $signed(op_b));
         BGE:   taken_nxt = ($signed(op_a) >= $signed(op_b));
         BLTU:  taken_nxt = (op_a < op_b);
         BGEU:  taken_nxt = (op_a >= op_b);
         default: res_nxt = '0;
      endcase
   end

   always_comb begin
      tgt_nxt = '0;
      if (dec.op == JALR) begin
         tgt_nxt = (rs1_data + dec.imm) & ~32'd1;
      end else if (is_branch || (dec.op == JAL)) begin
         tgt_nxt = dec.pc + dec.imm;
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         taken   <= 1'b0;
         wr_en   <= 1'b0;
         illegal <= 1'b0;
      end else if (state == S_EXECUTE) begin
         taken   <= taken_nxt;
         wr_en   <= (dec.op != ILLEGAL) && !is_branch;
         illegal <= (dec.op == ILLEGAL);
      end
   end

   always_ff @(posedge clk) begin
      if (state == S_EXECUTE) begin
         result <= res_nxt;
         target <= tgt_nxt;
      end
   end

endmodule

/* hw/rv_exec_top.sv */
`timescale 1ns/10ps

module rv_exec_top #(
   parameter int REG_COUNT = 32
) (
   input  logic             clk,
   input  logic             rst_n,
   input  logic             in_valid,
   input  rv_pkg::instr_t   in_instr,
   input  rv_pkg::word_t    in_pc,
   output logic             busy,
   output logic             out_valid,
   output rv_pkg::reg_idx_t out_rd,
   output rv_pkg::word_t    out_data,
   output logic             out_taken,
   output rv_pkg::word_t    out_target,
   output logic             out_illegal
);
   import rv_pkg::*;

   instr_t      instr_raw;
   word_t       pc;
   ctrl_state_e state;
   word_t       rs1_data;
   word_t       rs2_data;
   word_t       result;
   word_t       target;
   logic        taken;
   logic        wr_en;
   logic        illegal;
   logic        rf_we;

   decoded_if dec_if ();

   exec_ctrl exec_ctrl_i (
      .clk       (clk),
      .rst_n     (rst_n),
      .in_valid  (in_valid),
      .in_instr  (in_instr),
      .in_pc     (in_pc),
      .instr_raw (instr_raw),
      .pc        (pc),
      .state     (state),
      .busy      (busy)
   );

   instr_decoder #(
      .REG_COUNT (REG_COUNT)
   ) instr_decoder_i (
      .clk       (clk),
      .rst_n     (rst_n),
      .state     (state),
      .instr_raw (instr_raw),
      .pc        (pc),
      .dec       (dec_if)
   );

   // write lands on the edge that leaves writeback
   assign rf_we = (state == S_WRITEBACK) && wr_en;

   reg_file #(
      .REG_COUNT (REG_COUNT)
   ) reg_file_i (
      .clk      (clk),
      .rst_n    (rst_n),
      .rs1_addr (dec_if.rs1),
      .rs2_addr (dec_if.rs2),
      .rs1_data (rs1_data),
      .rs2_data (rs2_data),
      .we       (rf_we),
      .wr_addr  (dec_if.rd),
      .wr_data  (result)
   );

   int_alu int_alu_i (
      .clk      (clk),
      .rst_n    (rst_n),
      .state    (state),
      .dec      (dec_if),
      .rs1_data (rs1_data),
      .rs2_data (rs2_data),
      .result   (result),
      .target   (target),
      .taken    (taken),
      .wr_en    (wr_en),
      .illegal  (illegal)
   );

   assign out_valid   = (state == S_WRITEBACK);
   assign out_rd      = dec_if.rd;
   assign out_data    = result;
   assign out_taken   = taken;
   assign out_target  = target;
   assign out_illegal = illegal;

endmodule

/* bench/rv_exec_props.sv */
`timescale 1ns/10ps

module rv_exec_props (
   input logic                clk,
   input logic                rst_n,
   input logic                in_valid,
   input logic                busy,
   input logic                out_valid,
   input rv_pkg::ctrl_state_e state
);
   import rv_pkg::*;

   // one result pulse per instruction
   a_valid_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
      out_valid |=> !out_valid)
      else $error("out_valid high for more than one cycle");

   // accepted strobe to writeback takes three edges
   a_accept_latency: assert property (@(posedge clk) disable iff (!rst_n)
      (in_valid && !busy) |-> ##3 out_valid)
      else $error("out_valid missing three cycles after an accepted instruction");

   a_idle_after_reset: assert property (@(posedge clk)
      $rose(rst_n) |-> !busy)
      else $error("busy high right after reset");

   a_no_valid_in_idle: assert property (@(posedge clk) disable iff (!rst_n)
      (state == S_IDLE) |-> !out_valid)
      else $error("out_valid high while the controller is idle");

endmodule

bind rv_exec_top rv_exec_props rv_exec_props_i (
   .clk       (clk),
   .rst_n     (rst_n),
   .in_valid  (in_valid),
   .busy      (busy),
   .out_valid (out_valid),
   .state     (state)
);

/* bench/tb_rv_exec.sv */
`timescale 1ns/10ps

module tb_rv_exec;

   localparam int RESET_CYCLES   = 3;
   localparam int N_ENTRIES      = 33;
   localparam int TIMEOUT_CYCLES = N_ENTRIES * 8 + RESET_CYCLES;

   // major opcodes used by the encoders
   localparam logic [31:0] OPC_IMM   = 32'h13;
   localparam logic [31:0] OPC_LUI   = 32'h37;
   localparam logic [31:0] OPC_AUIPC = 32'h17;
   localparam logic [31:0] OPC_JALR  = 32'h67;
   localparam logic [31:0] OPC_LOAD  = 32'h03;

   logic        clk;
   logic        rst_n;
   logic        in_valid;
   logic [31:0] in_instr;
   logic [31:0] in_pc;
   logic        busy;
   logic        out_valid;
   logic [4:0]  out_rd;
   logic [31:0] out_data;
   logic        out_taken;
   logic [31:0] out_target;
   logic        out_illegal;

   logic [31:0] tab_instr   [N_ENTRIES];
   logic [31:0] tab_pc      [N_ENTRIES];
   logic [31:0] tab_rd      [N_ENTRIES];
   logic [31:0] tab_data    [N_ENTRIES];
   logic [31:0] tab_taken   [N_ENTRIES];
   logic [31:0] tab_target  [N_ENTRIES];
   logic [31:0] tab_illegal [N_ENTRIES];
   int          n_ent;
   int          cur_entry;
   int          errors;
   int          cycle_cnt;

   rv_exec_top #(
      .REG_COUNT (32)
   ) rv_exec_top_i (
      .clk         (clk),
      .rst_n       (rst_n),
      .in_valid    (in_valid),
      .in_instr    (in_instr),
      .in_pc       (in_pc),
      .busy        (busy),
      .out_valid   (out_valid),
      .out_rd      (out_rd),
      .out_data    (out_data),
      .out_taken   (out_taken),
      .out_target  (out_target),
      .out_illegal (out_illegal)
   );

   function automatic logic [31:0] encode_r(input logic [31:0] f7, rs2, rs1, f3, rd);
      return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0110011};
   endfunction

   function automatic logic [31:0] encode_i(input logic [31:0] imm, rs1, f3, rd, opc);
      return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], opc[6:0]};
   endfunction

   function automatic logic [31:0] encode_b(input logic [31:0] imm, rs2, rs1, f3);
      return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11],
              7'b1100011};
   endfunction

   function automatic logic [31:0] encode_u(input logic [31:0] imm20, rd, opc);
      return {imm20[19:0], rd[4:0], opc[6:0]};
   endfunction

   function automatic logic [31:0] encode_j(input logic [31:0] imm, rd);
      return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'b1101111};
   endfunction

   task automatic add_entry(input logic [31:0] instr, pc, rd, data, taken, target, illegal);
      tab_instr[n_ent]   = instr;
      tab_pc[n_ent]      = pc;
      tab_rd[n_ent]      = rd;
      tab_data[n_ent]    = data;
      tab_taken[n_ent]   = taken;
      tab_target[n_ent]  = target;
      tab_illegal[n_ent] = illegal;
      n_ent++;
   endtask

   task automatic check_value(input string name, input logic [31:0] got, exp);
      if (got !== exp) begin
         errors++;
         $display("ERR entry %0d %s: got %h, expected %h", cur_entry, name, got, exp);
      end
   endtask

   // register image x1=-1 x2=5 x3=80000000 with later entries reading earlier results
   task automatic build_table;
      add_entry(encode_i(-1, 0, 0, 1, OPC_IMM), 32'h100, 1, 32'hffffffff, 0, 0, 0);
      add_entry(encode_i(5, 0, 0, 2, OPC_IMM), 32'h104, 2, 32'h5, 0, 0, 0);
      add_entry(encode_u(32'h80000, 3, OPC_LUI), 32'h108, 3, 32'h80000000, 0, 0, 0);
      add_entry(encode_u(32'h12345, 4, OPC_AUIPC), 32'h1000, 4, 32'h12346000, 0, 0, 0);
      add_entry(encode_i(-8, 2, 0, 5, OPC_IMM), 32'h10c, 5, 32'hfffffffd, 0, 0, 0);
      // srai x21, x3, 4
      add_entry(encode_i(32'h404, 3, 5, 21, OPC_IMM), 32'h110, 21, 32'hf8000000, 0, 0, 0);
      add_entry(encode_r(0, 2, 1, 0, 6), 32'h114, 6, 32'h4, 0, 0, 0);
      add_entry(encode_r(32, 1, 2, 0, 7), 32'h118, 7, 32'h6, 0, 0, 0);
      add_entry(encode_r(0, 2, 2, 1, 8), 32'h11c, 8, 32'ha0, 0, 0, 0);
      add_entry(encode_r(0, 2, 1, 2, 9), 32'h120, 9, 32'h1, 0, 0, 0);
      add_entry(encode_r(0, 2, 1, 3, 10), 32'h124, 10, 32'h0, 0, 0, 0);
      add_entry(encode_r(0, 1, 3, 4, 11), 32'h128, 11, 32'h7fffffff, 0, 0, 0);
      add_entry(encode_r(0, 2, 3, 5, 12), 32'h12c, 12, 32'h04000000, 0, 0, 0);
      add_entry(encode_r(32, 2, 3, 5, 13), 32'h130, 13, 32'hfc000000, 0, 0, 0);
      add_entry(encode_r(0, 2, 8, 6, 14), 32'h134, 14, 32'ha5, 0, 0, 0);
      add_entry(encode_r(0, 7, 14, 7, 15), 32'h138, 15, 32'h4, 0, 0, 0);
      // branches on x6=4, x15=4, x1=-1, x2=5
      add_entry(encode_b(16, 15, 6, 0), 32'h200, 0, 0, 1, 32'h210, 0);
      add_entry(encode_b(-8, 15, 6, 1), 32'h210, 0, 0, 0, 32'h208, 0);
      add_entry(encode_b(-32, 2, 1, 4), 32'h300, 0, 0, 1, 32'h2e0, 0);
      add_entry(encode_b(8, 2, 1, 5), 32'h300, 0, 0, 0, 32'h308, 0);
      add_entry(encode_b(12, 2, 1, 6), 32'h400, 0, 0, 0, 32'h40c, 0);
      add_entry(encode_b(-4, 2, 1, 7), 32'h400, 0, 0, 1, 32'h3fc, 0);
      add_entry(encode_j(-256, 16), 32'h800, 16, 32'h804, 1, 32'h700, 0);
      add_entry(encode_i(32'h33, 7, 0, 17, OPC_JALR), 32'h900, 17, 32'h904, 1, 32'h38, 0);
      // addi x0 then read x0
      add_entry(encode_i(7, 2, 0, 0, OPC_IMM), 32'h13c, 0, 32'hc, 0, 0, 0);
      add_entry(encode_r(0, 17, 0, 0, 18), 32'h140, 18, 32'h904, 0, 0, 0);
      // lw, mul and add with funct7 0100001
      add_entry(encode_i(0, 2, 2, 19, OPC_LOAD), 32'h144, 0, 0, 0, 0, 1);
      add_entry(encode_r(1, 2, 2, 0, 19), 32'h148, 0, 0, 0, 0, 1);
      add_entry(encode_r(33, 2, 2, 0, 19), 32'h14c, 0, 0, 0, 0, 1);
      add_entry(encode_r(0, 2, 19, 0, 20), 32'h150, 20, 32'h5, 0, 0, 0);
      add_entry(encode_r(32, 9, 13, 0, 22), 32'h154, 22, 32'hfbffffff, 0, 0, 0);
      // xor, srl and sltu results read back as operands
      add_entry(encode_r(0, 12, 11, 4, 23), 32'h158, 23, 32'h7bffffff, 0, 0, 0);
      add_entry(encode_r(0, 10, 23, 0, 24), 32'h15c, 24, 32'h7bffffff, 0, 0, 0);
   endtask

   task automatic wait_result;
      @(negedge clk);
      while (!out_valid) begin
         @(negedge clk);
      end
   endtask

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   initial begin
      cycle_cnt = 0;
      while (cycle_cnt < TIMEOUT_CYCLES) begin
         @(posedge clk);
         cycle_cnt++;
      end
      $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("ERRORS FOUND");
      $finish;
   end

   initial begin
      rst_n     = 1'b0;
      in_valid  = 1'b0;
      in_instr  = '0;
      in_pc     = '0;
      n_ent     = 0;
      cur_entry = 0;
      errors    = 0;
      build_table();
      repeat (RESET_CYCLES) @(posedge clk);
      rst_n <= 1'b1;
      for (int i = 0; i < n_ent; i++) begin
         @(posedge clk);
         in_valid <= 1'b1;
         in_instr <= tab_instr[i];
         in_pc    <= tab_pc[i];
         cur_entry = i;
         // controller is back in idle before the strobe is sampled
         @(negedge clk);
         check_value("busy", 32'(busy), 32'd0);
         @(posedge clk);
         in_valid <= 1'b0;
         wait_result();
         check_value("busy", 32'(busy), 32'd1);
         check_value("out_rd", 32'(out_rd), tab_rd[i]);
         check_value("out_data", out_data, tab_data[i]);
         check_value("out_taken", 32'(out_taken), tab_taken[i]);
         check_value("out_target", out_target, tab_target[i]);
         check_value("out_illegal", 32'(out_illegal), tab_illegal[i]);
      end
      @(posedge clk);
      $display("run complete: %0d entries, %0d errors", n_ent, errors);
      if (errors == 0) begin
         $display("NO ERRORS");
      end else begin
         $display("ERRORS FOUND");
      end
      $finish;
   end

endmodule

/* project.f */
common/rv_pkg.sv
common/decoded_if.sv
hw/exec_ctrl.sv
decode/instr_decoder.sv
hw/reg_file.sv
exec/int_alu.sv
hw/rv_exec_top.sv
bench/rv_exec_props.sv
bench/tb_rv_exec.sv

/* run_sim.sh */
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/10ps \
   --top-module tb_rv_exec -f project.f -Mdir obj_dir -o sim_rv_exec \
   > build.log 2>&1 || { echo "build failed, see build.log"; exit 1; }

./obj_dir/sim_rv_exec > sim.log 2>&1 \
   && ! grep -q "ERRORS FOUND" sim.log \
   && echo "simulation passed" \
   || { echo "simulation failed, see sim.log"; exit 1; }
